//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = pit_tb
FILELIST = src.f
LOG      = sim.log
FAIL_MSG = *** TEST FAILED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- sim/pit_sva.sv
// Handshake and output assertions for the interval timer, bound into the top level
`timescale 1ns/1ps

module pit_sva (
  input logic       WR_,
  input logic       LOAD,
  input logic       req_ready,
  input logic       rsp_valid,
  input logic       rsp_ready,
  input logic [7:0] rsp_rdata,
  input logic [2:0] out
);

  // Response stays up with the same byte until taken
  a_rsp_hold: assert property (@(posedge WR_) disable iff (LOAD)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
    else $error("Response dropped or changed before it was accepted");

  a_req_stall: assert property (@(posedge WR_) disable iff (LOAD)
    rsp_valid |-> !req_ready)
    else $error("Request side ready while a response is pending");

  a_out_known: assert property (@(posedge WR_) disable iff (LOAD)
    !$isunknown(out))
    else $error("Channel output unknown after reset");

endmodule

bind pit_top pit_sva i_pit_sva (
  .WR_       (WR_),
  .LOAD      (LOAD),
  .req_ready (req_ready),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .rsp_rdata (rsp_rdata),
  .out       (out)
);

//--- sim/pit_tb.sv
// Directed testbench for the interval timer that runs as top module with the DUT and bound assertions
`timescale 1ns/1ps

module pit_tb;

  localparam int MAX_CYCLES = 4000;  // Summed test length with margin

  logic       WR_;
  logic       LOAD;
  logic       req_valid;
  logic       req_write;
  logic [1:0] req_addr;
  logic [7:0] req_wdata;
  logic       req_ready;
  logic       rsp_valid;
  logic       rsp_ready;
  logic [7:0] rsp_rdata;
  logic [2:0] tick;
  logic [2:0] gate;
  logic [2:0] out;
  int         checks;
  int         errors;
  int         cycles;

  pit_top i_pit_top (
    .WR_       (WR_),
    .LOAD      (LOAD),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata),
    .tick      (tick),
    .gate      (gate),
    .out       (out)
  );

  initial begin
    WR_ = 1'b0;
    forever #4 WR_ = ~WR_;
  end

  task automatic check(input logic [15:0] got, input logic [15:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Control word fields in bus order with the BCD bit clear
  function automatic logic [7:0] ctrl_word(input logic [1:0] sel, input logic [1:0] acc,
                                           input logic [2:0] mode);
    return {sel, acc, mode, 1'b0};
  endfunction

  task automatic wait_accept;
    logic ready_seen;
    ready_seen = 1'b0;
    while (!ready_seen) begin
      @(negedge WR_);
      ready_seen = req_ready;  // req_ready only moves on the rising edge
      @(posedge WR_);
    end
    req_valid <= 1'b0;
  endtask

  task automatic bus_write(input logic [1:0] addr, input logic [7:0] data);
    @(posedge WR_);
    req_valid <= 1'b1;
    req_write <= 1'b1;
    req_addr  <= addr;
    req_wdata <= data;
    wait_accept();
  endtask

  // hold gives the number of cycles rsp_ready stays low once the response is up
  task automatic bus_read(input logic [1:0] addr, input int hold, output logic [7:0] data);
    logic [7:0] held;
    @(posedge WR_);
    req_valid <= 1'b1;
    req_write <= 1'b0;
    req_addr  <= addr;
    rsp_ready <= (hold == 0);
    wait_accept();
    @(negedge WR_);
    while (!rsp_valid) begin
      @(negedge WR_);
    end
    held = rsp_rdata;
    for (int i = 0; i < hold; i++) begin
      check(16'(req_ready), 16'd0, "req_ready low while response pending");
      @(posedge WR_);
      @(negedge WR_);
      check(16'(rsp_valid), 16'd1, "rsp_valid held under back-pressure");
      check(16'(rsp_rdata), 16'(held), "rsp_rdata stable under back-pressure");
    end
    if (hold > 0) begin
      @(posedge WR_);
      rsp_ready <= 1'b1;
      @(negedge WR_);
    end
    data = rsp_rdata;
    @(posedge WR_);  // Response accepted here
  endtask

  // One-cycle tick on a channel after a random gap with out sampled on the falling edge
  task automatic pulse_tick(input int ch, input logic g);
    repeat ($urandom % 3) @(posedge WR_);
    @(posedge WR_);
    tick     <= 3'b001 << ch;
    gate[ch] <= g;
    @(posedge WR_);
    tick <= 3'b000;
    @(negedge WR_);
  endtask

  task automatic test_term_count;
    int   n;
    int   counted;
    logic g;
    logic froze;
    n       = 6;
    counted = 0;
    froze   = 1'b0;
    bus_write(2'd3, ctrl_word(2'd0, 2'd3, 3'd0));
    bus_write(2'd0, 8'(n));
    bus_write(2'd0, 8'h00);
    pulse_tick(0, 1'b1);  // Loading tick
    check(16'(out[0]), 16'd0, "ch0 out low after load");
    while (counted < n + 2) begin
      if (counted == n - 1 && !froze) begin
        g     = 1'b0;  // Gated-off tick just before terminal count
        froze = 1'b1;
      end else begin
        g = ($urandom % 4) != 0;  // Gate low now and then
      end
      pulse_tick(0, g);
      if (g) begin
        counted++;
      end
      check(16'(out[0]), 16'(counted >= n), "ch0 terminal count out");
    end
  endtask

  task automatic test_rate_gen;
    int mc;
    bus_write(2'd3, ctrl_word(2'd1, 2'd3, 3'd2));
    bus_write(2'd1, 8'd5);
    bus_write(2'd1, 8'd0);
    pulse_tick(1, 1'b1);
    mc = 5;
    check(16'(out[1]), 16'd1, "ch1 out high after load");
    repeat (15) begin  // Three periods
      pulse_tick(1, 1'b1);
      mc = (mc == 1) ? 5 : mc - 1;
      check(16'(out[1]), 16'(mc != 1), "ch1 rate generator out");
    end
  endtask

  task automatic test_square_wave(input int n);
    int phase;
    bus_write(2'd3, ctrl_word(2'd2, 2'd3, 3'd3));
    bus_write(2'd2, 8'(n));
    bus_write(2'd2, 8'(n >> 8));
    pulse_tick(2, 1'b1);
    phase = 0;
    check(16'(out[2]), 16'd1, "ch2 out high after load");
    repeat (2 * n + 1) begin
      pulse_tick(2, 1'b1);
      phase = (phase + 1) % n;
      check(16'(out[2]), 16'(phase < (n + 1) / 2), "ch2 square wave phase");  // Odd N gets the longer high phase
    end
  endtask

  task automatic test_latch_readback;
    logic [15:0] mc;
    logic [15:0] latched;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic        fired;
    logic        exp_out;
    int          lows;
    bus_write(2'd3, ctrl_word(2'd0, 2'd3, 3'd4));
    bus_write(2'd0, 8'h05);
    bus_write(2'd0, 8'h01);
    pulse_tick(0, 1'b1);
    mc    = 16'h0105;
    fired = 1'b0;
    lows  = 0;
    repeat (3) begin
      pulse_tick(0, 1'b1);
      mc = mc - 16'd1;
      check(16'(out[0]), 16'd1, "ch0 strobe out idle high");
    end
    bus_write(2'd3, ctrl_word(2'd0, 2'd0, 3'd0));  // Latch command
    latched = mc;
    repeat (5) begin
      pulse_tick(0, 1'b1);
      mc = mc - 16'd1;
    end
    bus_read(2'd0, 0, lo);
    bus_read(2'd0, 0, hi);
    check({hi, lo}, latched, "ch0 latched count");
    bus_read(2'd0, 0, lo);
    bus_read(2'd0, 0, hi);
    check({hi, lo}, mc, "ch0 live count");
    repeat (int'(mc) + 3) begin  // Run past zero without reload
      pulse_tick(0, 1'b1);
      mc      = mc - 16'd1;
      exp_out = !(mc == 16'd0 && !fired);
      if (mc == 16'd0) begin
        fired = 1'b1;
      end
      if (!out[0]) begin
        lows++;
      end
      check(16'(out[0]), 16'(exp_out), "ch0 strobe out");
    end
    check(16'(lows), 16'd1, "ch0 strobe pulse count");
  endtask

  task automatic test_access_backpressure;
    logic [7:0] d;
    bus_write(2'd3, ctrl_word(2'd1, 2'd1, 3'd0));  // LSB only
    bus_write(2'd1, 8'h2a);
    pulse_tick(1, 1'b1);
    bus_read(2'd1, 0, d);
    check(16'(d), 16'h002a, "ch1 LSB-only count");
    pulse_tick(1, 1'b1);
    bus_read(2'd1, 5, d);
    check(16'(d), 16'h0029, "ch1 LSB after one tick, stalled response");
    bus_write(2'd3, ctrl_word(2'd1, 2'd2, 3'd0));  // MSB only
    bus_write(2'd1, 8'h03);
    pulse_tick(1, 1'b1);
    bus_read(2'd1, 0, d);
    check(16'(d), 16'h0003, "ch1 MSB-only count");
    pulse_tick(1, 1'b1);
    bus_read(2'd1, 0, d);
    check(16'(d), 16'h0002, "ch1 MSB after borrow");
    bus_read(2'd3, 0, d);
    check(16'(d), 16'h0000, "control address reads zero");
  endtask

  initial begin
    void'($urandom(32'h73ed));
    checks    = 0;
    errors    = 0;
    LOAD      = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = 2'd0;
    req_wdata = 8'h00;
    rsp_ready = 1'b1;
    tick      = 3'b000;
    gate      = 3'b000;
    repeat (4) @(posedge WR_);
    LOAD <= 1'b0;
    @(negedge WR_);
    check(16'(req_ready), 16'd1, "req_ready after reset");
    check(16'(rsp_valid), 16'd0, "rsp_valid after reset");
    check(16'(out), 16'd0, "out after reset");
    test_term_count();
    test_rate_gen();
    test_square_wave(6);
    test_square_wave(5);
    test_latch_readback();
    test_access_backpressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge WR_);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- src.f
verilog/pit_pkg.sv
verilog/pit_chan_if.sv
verilog/pit_bus_decode.sv
verilog/pit_counter.sv
verilog/pit_read_mux.sv
verilog/pit_top.sv
sim/pit_sva.sv
sim/pit_tb.sv

//--- verilog/pit_bus_decode.sv
// Request side of the timer bus: accepts requests and sends registered strobes to one channel
`timescale 1ns/1ps

module pit_bus_decode import pit_pkg::*; (
  input  logic       WR_,
  input  logic       LOAD,
  input  logic       req_valid,
  input  logic       req_write,
  input  logic [1:0] req_addr,
  input  logic [7:0] req_wdata,
  output logic       req_ready,
  input  logic       rsp_done,
  pit_chan_if.decode chan [N_CHAN]
);

  logic       rd_pend;     // A read is in flight
  logic       accept;
  logic       is_ctrl;
  logic       ctrl_latch;
  logic [1:0] ctrl_sel;

  assign accept     = req_valid & req_ready;
  assign is_ctrl    = (req_addr == CTRL_ADDR);
  assign ctrl_sel   = req_wdata[SEL_MSB:SEL_LSB];
  assign ctrl_latch = (pit_access_e'(req_wdata[ACC_LSB_POS +: 2]) == ACC_LATCH);
  assign req_ready  = ~rd_pend;  // Stall everything while a read is outstanding

  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      rd_pend <= 1'b0;
    end else if (accept && !req_write) begin
      rd_pend <= 1'b1;
    end else if (rsp_done) begin
      rd_pend <= 1'b0;
    end
  end

  for (genvar i = 0; i < N_CHAN; i++) begin : g_strobe
    logic hit_data;
    logic hit_ctrl;
    logic ctrl_rd;

    assign hit_data = accept && !is_ctrl && (req_addr == 2'(i));
    assign hit_ctrl = accept && req_write && is_ctrl && (ctrl_sel == 2'(i));
    // Control port has no read-back, channel 0 answers it with zero
    assign ctrl_rd  = accept && !req_write && is_ctrl && (i == 0);

    always_ff @(posedge WR_ or posedge LOAD) begin
      if (LOAD) begin
        chan[i].wr_en    <= 1'b0;
        chan[i].rd_en    <= 1'b0;
        chan[i].ctrl_en  <= 1'b0;
        chan[i].latch_en <= 1'b0;
      end else begin
        chan[i].wr_en    <= hit_data && req_write;
        chan[i].rd_en    <= (hit_data && !req_write) || ctrl_rd;
        chan[i].ctrl_en  <= (hit_ctrl && !ctrl_latch) || ctrl_rd;
        chan[i].latch_en <= hit_ctrl && ctrl_latch;
      end
    end

    always_ff @(posedge WR_) begin
      if (accept) begin
        chan[i].wdata <= req_wdata;
      end
    end
  end

endmodule

//--- verilog/pit_chan_if.sv
// Strobe and data bundle between the bus decoder, one timer channel and the read mux
`timescale 1ns/1ps

interface pit_chan_if;

  logic       wr_en;     // Data byte for this channel
  logic       ctrl_en;   // New mode and access word
  logic       latch_en;  // Counter latch command
  logic       rd_en;     // Read of this channel
  logic [7:0] wdata;
  logic [7:0] rdata;     // Registered by the channel

  modport decode (
    output wr_en, ctrl_en, latch_en, rd_en, wdata
  );

  modport chan (
    input  wr_en, ctrl_en, latch_en, rd_en, wdata,
    output rdata
  );

  modport rmux (
    input rd_en, rdata
  );

endinterface

//--- verilog/pit_counter.sv
// One timer channel: mode and count registers, 16-bit down counter, out logic and count latch
`timescale 1ns/1ps

module pit_counter import pit_pkg::*; (
  input  logic WR_,
  input  logic LOAD,
  input  logic tick,
  input  logic gate,
  output logic out,
  pit_chan_if.chan bus
);

  localparam int CNT_W = 16;

  pit_mode_e   mode;
  pit_mode_e   new_mode;
  pit_access_e acc;
  logic             wr_msb;       // Next ACC_BOTH write is the MSB
  logic             rd_msb;       // Next ACC_BOTH read is the MSB
  logic             load_pend;    // Complete count waiting for a tick
  logic             armed;        // Counter holds a valid count
  logic             done;         // Strobe already fired
  logic             latch_valid;
  logic [CNT_W-1:0] count_reg;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] latch;
  logic [CNT_W-1:0] rd_val;
  logic [7:0]       rd_byte;
  logic             ctrl_wr;
  logic             ctrl_rd;
  logic             data_rd;

  function automatic pit_mode_e to_mode(input logic [2:0] code);
    case (code)
      3'd2:    return MODE_RATE;
      3'd3:    return MODE_SQUARE;
      3'd4:    return MODE_STROBE;
      default: return MODE_TERM;
    endcase
  endfunction

  // Even start value for a square-wave half period, odd N gives the high half the extra tick
  function automatic logic [CNT_W-1:0] sq_load(input logic [CNT_W-1:0] n, input logic hi);
    if (!n[0]) begin
      return n;
    end
    return hi ? n + 1'b1 : n - 1'b1;
  endfunction

  assign new_mode = to_mode(bus.wdata[MODE_LSB_POS +: 3]);
  assign ctrl_wr  = bus.ctrl_en & ~bus.rd_en;
  assign ctrl_rd  = bus.ctrl_en & bus.rd_en;
  assign data_rd  = bus.rd_en & ~bus.ctrl_en;

  assign rd_val  = latch_valid ? latch : cnt;
  assign rd_byte = ((acc == ACC_MSB) || (acc == ACC_BOTH && rd_msb)) ? rd_val[15:8]
                                                                     : rd_val[7:0];

  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      mode        <= MODE_TERM;
      acc         <= ACC_BOTH;
      wr_msb      <= 1'b0;
      rd_msb      <= 1'b0;
      load_pend   <= 1'b0;
      armed       <= 1'b0;
      done        <= 1'b0;
      latch_valid <= 1'b0;
      cnt         <= '0;
      out         <= 1'b0;
    end else begin
      if (tick) begin
        if (load_pend) begin                     // Loading tick
          load_pend <= 1'b0;
          armed     <= 1'b1;
          done      <= 1'b0;
          cnt       <= (mode == MODE_SQUARE) ? sq_load(count_reg, 1'b1) : count_reg;
          out       <= (mode != MODE_TERM);
        end else if (armed && gate) begin
          case (mode)
            MODE_RATE: begin
              if (cnt == 16'd1) begin
                cnt <= count_reg;                // Reload, period of N ticks
                out <= 1'b1;
              end else begin
                cnt <= cnt - 1'b1;
                out <= (cnt != 16'd2);           // Low while counter is 1
              end
            end
            MODE_SQUARE: begin
              if (cnt == 16'd2) begin
                cnt <= sq_load(count_reg, ~out);
                out <= ~out;
              end else begin
                cnt <= cnt - 2'd2;
              end
            end
            MODE_STROBE: begin
              cnt <= cnt - 1'b1;
              out <= !(cnt == 16'd1 && !done);   // Single low pulse at zero
              if (cnt == 16'd1) begin
                done <= 1'b1;
              end
            end
            default: begin
              cnt <= cnt - 1'b1;
              if (cnt == 16'd1) begin
                out <= 1'b1;                     // Terminal count, stays high
              end
            end
          endcase
        end else if (armed && mode == MODE_STROBE) begin
          out <= 1'b1;  // Strobe still ends while gated off
        end
      end

      if (ctrl_wr) begin
        mode        <= new_mode;
        acc         <= pit_access_e'(bus.wdata[ACC_LSB_POS +: 2]);
        wr_msb      <= 1'b0;
        rd_msb      <= 1'b0;
        load_pend   <= 1'b0;
        armed       <= 1'b0;
        latch_valid <= 1'b0;
        out         <= (new_mode != MODE_TERM);
      end

      if (bus.wr_en) begin
        if (acc == ACC_BOTH) begin
          wr_msb <= ~wr_msb;
          if (wr_msb) begin
            load_pend <= 1'b1;
          end
        end else begin
          load_pend <= 1'b1;
        end
      end

      if (bus.latch_en && !latch_valid) begin
        latch_valid <= 1'b1;  // Later latch commands ignored until read out
      end

      if (data_rd) begin
        if (acc == ACC_BOTH) begin
          rd_msb <= ~rd_msb;
          if (rd_msb) begin
            latch_valid <= 1'b0;
          end
        end else begin
          latch_valid <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge WR_) begin
    if (bus.wr_en) begin
      case (acc)
        ACC_LSB: count_reg <= {8'h00, bus.wdata};
        ACC_MSB: count_reg <= {bus.wdata, 8'h00};
        default: begin
          if (wr_msb) begin
            count_reg[15:8] <= bus.wdata;
          end else begin
            count_reg[7:0] <= bus.wdata;
          end
        end
      endcase
    end
    if (bus.latch_en && !latch_valid) begin
      latch <= cnt;
    end
    if (bus.rd_en) begin
      bus.rdata <= ctrl_rd ? 8'h00 : rd_byte;
    end
  end

endmodule

//--- verilog/pit_pkg.sv
// Types and constants for the three-channel interval timer, imported by every RTL file
package pit_pkg;

  // Number of counter channels, one per data address
  localparam int N_CHAN = 3;

  // Control word lives at the last bus address
  localparam logic [1:0] CTRL_ADDR = 2'd3;

  // Control word layout
  localparam int SEL_LSB      = 6;  // Bits 7:6 channel select
  localparam int SEL_MSB      = 7;
  localparam int ACC_LSB_POS  = 4;  // Bits 5:4 access mode
  localparam int MODE_LSB_POS = 1;  // Bits 3:1 counter mode, bit 0 (BCD) unused

  // Supported counter modes, other codes fall back to MODE_TERM
  typedef enum logic [2:0] {
    MODE_TERM   = 3'd0,  // Interrupt on terminal count
    MODE_RATE   = 3'd2,  // Rate generator
    MODE_SQUARE = 3'd3,  // Square wave
    MODE_STROBE = 3'd4   // Software strobe
  } pit_mode_e;

  // Read/write access modes from the control word
  typedef enum logic [1:0] {
    ACC_LATCH = 2'd0,  // Counter latch command
    ACC_LSB   = 2'd1,
    ACC_MSB   = 2'd2,
    ACC_BOTH  = 2'd3   // LSB then MSB
  } pit_access_e;

endpackage

//--- verilog/pit_read_mux.sv
// Response side of the timer bus: picks the strobed channel's byte and holds it until accepted
`timescale 1ns/1ps

module pit_read_mux import pit_pkg::*; (
  input  logic       WR_,
  input  logic       LOAD,
  pit_chan_if.rmux   chan [N_CHAN],
  output logic       rsp_valid,
  input  logic       rsp_ready,
  output logic [7:0] rsp_rdata,
  output logic       rsp_done
);

  localparam int IW = $clog2(N_CHAN);

  logic [N_CHAN-1:0] rd_vec;
  logic [7:0]        rdata_arr [N_CHAN];
  logic [IW-1:0]     rd_idx;
  logic [IW-1:0]     sel_q;    // Channel read last cycle
  logic              capture;  // Channel rdata is ready this cycle

  for (genvar i = 0; i < N_CHAN; i++) begin : g_gather
    assign rd_vec[i]    = chan[i].rd_en;
    assign rdata_arr[i] = chan[i].rdata;
  end

  always_comb begin
    rd_idx = '0;
    for (int k = 0; k < N_CHAN; k++) begin
      if (rd_vec[k]) begin
        rd_idx = IW'(k);
      end
    end
  end

  assign rsp_done = rsp_valid & rsp_ready;

  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      capture   <= 1'b0;
      sel_q     <= '0;
      rsp_valid <= 1'b0;
    end else begin
      capture <= |rd_vec;
      if (|rd_vec) begin
        sel_q <= rd_idx;
      end
      if (capture) begin
        rsp_valid <= 1'b1;
      end else if (rsp_done) begin
        rsp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge WR_) begin
    if (capture) begin
      rsp_rdata <= rdata_arr[sel_q];  // Held until the next read
    end
  end

endmodule

//--- verilog/pit_top.sv
// Top level of the three-channel interval timer, with plain bus, tick, gate and out ports
`timescale 1ns/1ps

module pit_top import pit_pkg::*; (
  input  logic       WR_,
  input  logic       LOAD,
  input  logic       req_valid,
  input  logic       req_write,
  input  logic [1:0] req_addr,
  input  logic [7:0] req_wdata,
  output logic       req_ready,
  output logic       rsp_valid,
  input  logic       rsp_ready,
  output logic [7:0] rsp_rdata,
  input  logic [2:0] tick,
  input  logic [2:0] gate,
  output logic [2:0] out
);

  logic rsp_done;  // Read response taken, frees the request side

  pit_chan_if chan_if [N_CHAN] ();

  pit_bus_decode i_pit_bus_decode (
    .WR_       (WR_),
    .LOAD      (LOAD),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_ready (req_ready),
    .rsp_done  (rsp_done),
    .chan      (chan_if)
  );

  for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
    pit_counter i_pit_counter (
      .WR_  (WR_),
      .LOAD (LOAD),
      .tick (tick[i]),
      .gate (gate[i]),
      .out  (out[i]),
      .bus  (chan_if[i])
    );
  end

  pit_read_mux i_pit_read_mux (
    .WR_       (WR_),
    .LOAD      (LOAD),
    .chan      (chan_if),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata),
    .rsp_done  (rsp_done)
  );

endmodule
